// File: verilog/blimp_pkg.sv
// Blimp core shared definitions
// Word and register index types, RV32 opcode fields, micro-ops and
// the fetch handshake states

package blimp_pkg;

  //----------------------------------------------------------
  // Widths
  //----------------------------------------------------------

  typedef logic [31:0] word_t;    // Data word, instruction or PC
  typedef logic [4:0]  reg_idx_t; // Architectural register index

  //----------------------------------------------------------
  // Micro-ops and FSM states
  //----------------------------------------------------------

  typedef enum logic [1:0] {
    UOP_ADD,  // rd = rs1 + rs2
    UOP_ADDI, // rd = rs1 + sext(imm)
    UOP_MUL   // rd = low 32 bits of rs1 * rs2
  } uop_e;

  typedef enum logic [1:0] {
    FETCH_REQ,       // Idle, may raise req
    FETCH_WAIT_ACK,  // req high, waiting for ack
    FETCH_WAIT_DROP  // req dropped, waiting for ack to fall
  } fetch_state_e;

  //----------------------------------------------------------
  // Encodings
  //----------------------------------------------------------

  localparam logic [6:0] OPC_OP     = 7'b0110011; // Register-register
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011; // Register-immediate
  localparam logic [6:0] F7_ADD     = 7'b0000000;
  localparam logic [6:0] F7_MUL     = 7'b0000001; // M extension

  // addi x0, x0, 0
  localparam word_t NOP_INSTR = 32'h0000_0013;

endpackage

// File: verilog/fetch_unit.sv
// Blimp fetch unit
// Sequential PC, four-phase client of the instruction memory and a
// one-entry buffer toward decode
`timescale 1ns/10ps

module fetch_unit
  import blimp_pkg::*;
(
  input  logic  clk,
  input  logic  rst_n,
  output logic  imem_req,
  output word_t imem_addr,
  input  logic  imem_ack,
  input  word_t imem_data,
  output logic  f_val,
  output word_t f_pc,
  output word_t f_instr,
  input  logic  f_rdy
);

  fetch_state_e state;
  word_t        pc;   // Address of the next request

  assign imem_addr = pc; // Only moves when req drops

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state    <= FETCH_REQ;
      pc       <= '0;
      imem_req <= 1'b0;
      f_val    <= 1'b0;
    end else begin
      if (f_val && f_rdy) f_val <= 1'b0; // Buffer consumed by decode
      case (state)
        FETCH_REQ: begin
          // Wait for an empty buffer and a quiet ack line
          if (!f_val && !imem_ack) begin
            imem_req <= 1'b1;
            state    <= FETCH_WAIT_ACK;
          end
        end
        FETCH_WAIT_ACK: begin
          if (imem_ack) begin
            imem_req <= 1'b0;
            f_val    <= 1'b1;       // Visible one cycle after ack
            pc       <= pc + 32'd4;
            state    <= FETCH_WAIT_DROP;
          end
        end
        FETCH_WAIT_DROP: begin
          if (!imem_ack) state <= FETCH_REQ; // Four-phase cycle closed
        end
        default: state <= FETCH_REQ;
      endcase
    end
  end

  // Buffer payload
  always_ff @(posedge clk) begin
    if (state == FETCH_WAIT_ACK && imem_ack) begin
      f_pc    <= pc;
      f_instr <= imem_data;
    end
  end

endmodule

// File: verilog/decode_issue_unit.sv
// Blimp decode and issue unit
// Decodes ADD/ADDI/MUL, reads the committed register file, tracks
// pending writers in a scoreboard and dispatches in order to the pipes
`timescale 1ns/10ps

module decode_issue_unit
  import blimp_pkg::*;
#(
  parameter p_seq_num_bits = 3
) (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      f_val,
  input  word_t                     f_pc,
  input  word_t                     f_instr,
  output logic                      f_rdy,
  output logic                      alu_val,
  output logic [p_seq_num_bits-1:0] alu_seq,
  output reg_idx_t                  alu_waddr,
  output word_t                     alu_a,
  output word_t                     alu_b,
  output logic                      mul_val,
  output logic [p_seq_num_bits-1:0] mul_seq,
  output reg_idx_t                  mul_waddr,
  output word_t                     mul_a,
  output word_t                     mul_b,
  output logic                      alloc_val,
  output logic [p_seq_num_bits-1:0] alloc_seq,
  output word_t                     alloc_pc,
  input  logic                      cmt_val,
  input  logic [p_seq_num_bits-1:0] cmt_seq,
  input  reg_idx_t                  cmt_waddr,
  input  word_t                     cmt_data
);

  logic     supported;
  word_t    instr;     // Decoded instruction, NOP if unsupported
  uop_e     uop;
  reg_idx_t rd;
  reg_idx_t rs1;
  reg_idx_t rs2;
  word_t    imm;
  logic     uses_rs2;
  logic     src_pend;
  logic     rf_conflict;
  logic     rob_full;
  logic     dispatch;

  word_t                     rf [32];      // Committed state
  logic [31:0]               sb_pend;      // Writer in flight
  logic [p_seq_num_bits-1:0] sb_seq [32];  // Newest writer's tag
  logic [p_seq_num_bits-1:0] next_seq;
  logic [p_seq_num_bits:0]   in_flight;

  //----------------------------------------------------------
  // Decode
  //----------------------------------------------------------

  always_comb begin
    supported = 1'b0;
    if (f_instr[14:12] == 3'b000) begin
      if (f_instr[6:0] == OPC_OP_IMM)
        supported = 1'b1;
      else if (f_instr[6:0] == OPC_OP &&
               (f_instr[31:25] == F7_ADD || f_instr[31:25] == F7_MUL))
        supported = 1'b1;
    end
  end

  assign instr = supported ? f_instr : NOP_INSTR;
  assign rd    = instr[11:7];
  assign rs1   = instr[19:15];
  assign rs2   = instr[24:20];
  assign imm   = {{20{instr[31]}}, instr[31:20]}; // I-type immediate

  always_comb begin
    if (instr[6:0] == OPC_OP_IMM) uop = UOP_ADDI;
    else if (instr[31:25] == F7_MUL) uop = UOP_MUL;
    else uop = UOP_ADD;
  end

  assign uses_rs2 = (uop != UOP_ADDI);

  //----------------------------------------------------------
  // Hazards and dispatch
  //----------------------------------------------------------

  assign src_pend    = sb_pend[rs1] || (uses_rs2 && sb_pend[rs2]);
  assign rf_conflict = cmt_val && (cmt_waddr != '0) &&
                       ((cmt_waddr == rs1) || (uses_rs2 && cmt_waddr == rs2));
  assign rob_full    = in_flight[p_seq_num_bits]; // MSB set only at 2**n

  assign f_rdy    = !(src_pend || rf_conflict || rob_full);
  assign dispatch = f_val && f_rdy;

  assign alu_val   = dispatch && (uop != UOP_MUL);
  assign alu_seq   = next_seq;
  assign alu_waddr = rd;
  assign alu_a     = rf[rs1];
  assign alu_b     = (uop == UOP_ADDI) ? imm : rf[rs2];

  assign mul_val   = dispatch && (uop == UOP_MUL);
  assign mul_seq   = next_seq;
  assign mul_waddr = rd;
  assign mul_a     = rf[rs1];
  assign mul_b     = rf[rs2];

  assign alloc_val = dispatch; // ROB entry opened with the PC
  assign alloc_seq = next_seq;
  assign alloc_pc  = f_pc;

  //----------------------------------------------------------
  // Register file, scoreboard, counters
  //----------------------------------------------------------

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      next_seq  <= '0;
      in_flight <= '0;
      sb_pend   <= '0;
      for (int i = 0; i < 32; i++) rf[i] <= '0;
    end else begin
      if (dispatch) next_seq <= next_seq + 1'b1;
      case ({dispatch, cmt_val})
        2'b10:   in_flight <= in_flight + 1'b1;
        2'b01:   in_flight <= in_flight - 1'b1;
        default: ;
      endcase
      if (cmt_val && cmt_waddr != '0) rf[cmt_waddr] <= cmt_data; // x0 stays 0
      // Clear only for the newest writer, older commits leave it pending
      if (cmt_val && sb_seq[cmt_waddr] == cmt_seq) sb_pend[cmt_waddr] <= 1'b0;
      if (dispatch && rd != '0) sb_pend[rd] <= 1'b1; // New writer wins
    end
  end

  always_ff @(posedge clk) begin
    if (dispatch && rd != '0) sb_seq[rd] <= next_seq;
  end

endmodule

// File: verilog/alu_unit.sv
// Blimp ALU pipe
// Single registered stage computing a + b for ADD and ADDI
`timescale 1ns/10ps

module alu_unit
  import blimp_pkg::*;
#(
  parameter p_seq_num_bits = 3
) (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      alu_val,
  input  logic [p_seq_num_bits-1:0] alu_seq,
  input  reg_idx_t                  alu_waddr,
  input  word_t                     alu_a,
  input  word_t                     alu_b,  // Immediate already extended
  output logic                      alu_cpl_val,
  output logic [p_seq_num_bits-1:0] alu_cpl_seq,
  output reg_idx_t                  alu_cpl_waddr,
  output word_t                     alu_cpl_data
);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) alu_cpl_val <= 1'b0;
    else alu_cpl_val <= alu_val;    // Completes next cycle
  end

  // Result and tag
  always_ff @(posedge clk) begin
    if (alu_val) begin
      alu_cpl_seq   <= alu_seq;
      alu_cpl_waddr <= alu_waddr;
      alu_cpl_data  <= alu_a + alu_b;
    end
  end

endmodule

// File: verilog/mul_unit.sv
// Blimp multiplier pipe
// Low 32 bits of a * b carried through p_mul_stages registers, one
// new multiply accepted every cycle
`timescale 1ns/10ps

module mul_unit
  import blimp_pkg::*;
#(
  parameter p_seq_num_bits = 3,
  parameter p_mul_stages   = 4
) (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      mul_val,
  input  logic [p_seq_num_bits-1:0] mul_seq,
  input  reg_idx_t                  mul_waddr,
  input  word_t                     mul_a,
  input  word_t                     mul_b,
  output logic                      mul_cpl_val,
  output logic [p_seq_num_bits-1:0] mul_cpl_seq,
  output reg_idx_t                  mul_cpl_waddr,
  output word_t                     mul_cpl_data
);

  word_t                     product;
  logic [p_mul_stages-1:0]   val_q;               // Valid shift chain
  logic [p_seq_num_bits-1:0] seq_q   [p_mul_stages];
  reg_idx_t                  waddr_q [p_mul_stages];
  word_t                     data_q  [p_mul_stages];

  assign product = mul_a * mul_b; // Upper half dropped

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      val_q <= '0;
    end else begin
      val_q[0] <= mul_val;
      for (int i = 1; i < p_mul_stages; i++) val_q[i] <= val_q[i-1];
    end
  end

  // Product and tag chain
  always_ff @(posedge clk) begin
    seq_q[0]   <= mul_seq;
    waddr_q[0] <= mul_waddr;
    data_q[0]  <= product;
    for (int i = 1; i < p_mul_stages; i++) begin
      seq_q[i]   <= seq_q[i-1];
      waddr_q[i] <= waddr_q[i-1];
      data_q[i]  <= data_q[i-1];
    end
  end

  // Last stage out
  assign mul_cpl_val   = val_q[p_mul_stages-1];
  assign mul_cpl_seq   = seq_q[p_mul_stages-1];
  assign mul_cpl_waddr = waddr_q[p_mul_stages-1];
  assign mul_cpl_data  = data_q[p_mul_stages-1];

endmodule

// File: verilog/writeback_commit_unit.sv
// Blimp writeback and commit unit
// Reorder buffer indexed by sequence number, takes ALU and multiplier
// completions out of order and commits in order onto the trace port
`timescale 1ns/10ps

module writeback_commit_unit
  import blimp_pkg::*;
#(
  parameter p_seq_num_bits = 3
) (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      alloc_val,
  input  logic [p_seq_num_bits-1:0] alloc_seq,
  input  word_t                     alloc_pc,
  input  logic                      alu_cpl_val,
  input  logic [p_seq_num_bits-1:0] alu_cpl_seq,
  input  reg_idx_t                  alu_cpl_waddr,
  input  word_t                     alu_cpl_data,
  input  logic                      mul_cpl_val,
  input  logic [p_seq_num_bits-1:0] mul_cpl_seq,
  input  reg_idx_t                  mul_cpl_waddr,
  input  word_t                     mul_cpl_data,
  output logic                      cmt_val,
  output logic [p_seq_num_bits-1:0] cmt_seq,
  output reg_idx_t                  cmt_waddr,
  output word_t                     cmt_data,
  output logic                      trace_val,
  output word_t                     trace_pc,
  output reg_idx_t                  trace_waddr,
  output word_t                     trace_wdata,
  output logic                      trace_wen
);

  localparam int unsigned p_entries = 2 ** p_seq_num_bits;

  word_t                     rob_pc    [p_entries];
  word_t                     rob_data  [p_entries];
  reg_idx_t                  rob_waddr [p_entries];
  logic [p_entries-1:0]      rob_done;  // Result written, not yet committed
  logic [p_seq_num_bits-1:0] head;      // Oldest in-flight tag

  //----------------------------------------------------------
  // Commit from the head
  //----------------------------------------------------------

  assign cmt_val   = rob_done[head]; // One cycle after completion at best
  assign cmt_seq   = head;
  assign cmt_waddr = rob_waddr[head];
  assign cmt_data  = rob_data[head];

  assign trace_val   = cmt_val;
  assign trace_pc    = rob_pc[head];
  assign trace_waddr = cmt_waddr;
  assign trace_wdata = cmt_data;
  assign trace_wen   = (cmt_waddr != '0); // x0 writes dropped

  //----------------------------------------------------------
  // Entry state
  //----------------------------------------------------------

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rob_done <= '0;
      head     <= '0;
    end else begin
      if (cmt_val) begin
        rob_done[head] <= 1'b0; // Free the entry
        head           <= head + 1'b1;
      end
      // Both pipes may finish together, tags always differ
      if (alu_cpl_val) rob_done[alu_cpl_seq] <= 1'b1;
      if (mul_cpl_val) rob_done[mul_cpl_seq] <= 1'b1;
    end
  end

  // Entry payload
  always_ff @(posedge clk) begin
    if (alloc_val) rob_pc[alloc_seq] <= alloc_pc;
    if (alu_cpl_val) begin
      rob_data[alu_cpl_seq]  <= alu_cpl_data;
      rob_waddr[alu_cpl_seq] <= alu_cpl_waddr;
    end
    if (mul_cpl_val) begin
      rob_data[mul_cpl_seq]  <= mul_cpl_data;
      rob_waddr[mul_cpl_seq] <= mul_cpl_waddr;
    end
  end

endmodule

// File: verilog/blimp_core.sv
// Blimp core top level
// In-order issue, out-of-order completion core for ADD, ADDI and MUL,
// fetch over a four-phase memory port, commits on the trace port
`timescale 1ns/10ps

module blimp_core
  import blimp_pkg::*;
#(
  parameter p_seq_num_bits = 3, // ROB holds 2**p_seq_num_bits entries
  parameter p_mul_stages   = 4
) (
  input  logic     clk,
  input  logic     rst_n,
  output logic     imem_req,
  output word_t    imem_addr,
  input  logic     imem_ack,
  input  word_t    imem_data,
  output logic     trace_val,
  output word_t    trace_pc,
  output reg_idx_t trace_waddr,
  output word_t    trace_wdata,
  output logic     trace_wen
);

  //----------------------------------------------------------
  // Unit wiring
  //----------------------------------------------------------

  logic f_val, f_rdy;                // Fetch to decode
  word_t f_pc, f_instr;

  logic alu_val, mul_val, alloc_val; // Dispatch
  logic [p_seq_num_bits-1:0] alu_seq, mul_seq, alloc_seq;
  reg_idx_t alu_waddr, mul_waddr;
  word_t alu_a, alu_b, mul_a, mul_b, alloc_pc;

  logic alu_cpl_val, mul_cpl_val;    // Completion
  logic [p_seq_num_bits-1:0] alu_cpl_seq, mul_cpl_seq;
  reg_idx_t alu_cpl_waddr, mul_cpl_waddr;
  word_t alu_cpl_data, mul_cpl_data;

  logic cmt_val;                     // Commit back to decode
  logic [p_seq_num_bits-1:0] cmt_seq;
  reg_idx_t cmt_waddr;
  word_t cmt_data;

  //----------------------------------------------------------
  // Units
  //----------------------------------------------------------

  fetch_unit i_fetch (.*);

  decode_issue_unit #(.p_seq_num_bits(p_seq_num_bits)) i_decode (.*);

  alu_unit #(.p_seq_num_bits(p_seq_num_bits)) i_alu (.*);

  mul_unit #(
    .p_seq_num_bits (p_seq_num_bits),
    .p_mul_stages   (p_mul_stages)
  ) i_mul (.*);

  writeback_commit_unit #(.p_seq_num_bits(p_seq_num_bits)) i_wcu (.*);

endmodule

// File: test/blimp_core_checker.sv
// Blimp core commit checker
// In-order ISA model of ADD, ADDI and MUL, compared against every
// commit that appears on the trace port
`timescale 1ns/10ps

module blimp_core_checker
  import blimp_pkg::*;
#(
  parameter int n_instr = 200
) (
  input  logic     clk,
  input  logic     rst_n,
  input  logic     trace_val,
  input  word_t    trace_pc,
  input  reg_idx_t trace_waddr,
  input  word_t    trace_wdata,
  input  logic     trace_wen,
  input  word_t    prog [n_instr],
  output int       err_count,
  output int       cmt_count  // Commits seen so far
);

  word_t model_rf [32]; // Architectural state with x0 held at 0

  // Compares one field and returns 1 on a difference
  function automatic int check_field(string name, word_t exp, word_t got);
    if (exp === got) return 0;
    $display("MISMATCH t=%0t %s expected %h got %h", $time, name, exp, got);
    return 1;
  endfunction

  //------------------------------------------------------------
  // Model step on each commit
  //------------------------------------------------------------

  always @(posedge clk) begin : model_step
    word_t    instr;
    word_t    src1;
    word_t    src2;
    word_t    exp_data;
    reg_idx_t exp_rd;
    int       errs;
    if (!rst_n) begin
      err_count <= 0;
      cmt_count <= 0;
      for (int i = 0; i < 32; i++) model_rf[i] = '0;
    end else if (trace_val) begin
      // Past the program the memory returns NOPs
      instr    = (cmt_count < n_instr) ? prog[cmt_count] : NOP_INSTR;
      src1     = model_rf[instr[19:15]];
      src2     = model_rf[instr[24:20]];
      exp_rd   = '0;  // Unsupported encodings behave as addi x0, x0, 0
      exp_data = '0;
      if (instr[14:12] == 3'b000) begin
        if (instr[6:0] == OPC_OP_IMM) begin
          exp_rd   = instr[11:7];
          exp_data = src1 + 32'($signed(instr[31:20])); // Sign-extended imm
        end else if (instr[6:0] == OPC_OP && instr[31:25] == F7_ADD) begin
          exp_rd   = instr[11:7];
          exp_data = src1 + src2;
        end else if (instr[6:0] == OPC_OP && instr[31:25] == F7_MUL) begin
          exp_rd   = instr[11:7];
          exp_data = src1 * src2; // Low half only
        end
      end
      errs = 0;
      errs += check_field("trace_pc", word_t'(cmt_count * 4), trace_pc);
      errs += check_field("trace_waddr", {27'd0, exp_rd}, {27'd0, trace_waddr});
      errs += check_field("trace_wdata", exp_data, trace_wdata);
      errs += check_field("trace_wen", {31'd0, exp_rd != '0}, {31'd0, trace_wen});
      if (exp_rd != '0) model_rf[exp_rd] = exp_data;
      err_count <= err_count + errs;
      cmt_count <= cmt_count + 1;
    end
  end

endmodule

// File: test/blimp_core_asserts.sv
// Blimp core protocol assertions
// Four-phase instruction-memory rules and reset values, bound into
// the core top level
`timescale 1ns/10ps

module blimp_core_asserts
  import blimp_pkg::*;
(
  input logic  clk,
  input logic  rst_n,
  input logic  imem_req,
  input word_t imem_addr,
  input logic  imem_ack,
  input logic  trace_val
);

  int   fail_count = 0;    // Failed assertion count
  logic in_reset_q = 1'b0; // Reset seen on the previous edge

  always @(posedge clk) in_reset_q <= !rst_n;

  //------------------------------------------------------------
  // Instruction-memory handshake
  //------------------------------------------------------------

  a_req_hold: assert property (@(posedge clk) disable iff (!rst_n)
    imem_req && !imem_ack |=> imem_req)
    else begin
      fail_count++;
      $error("imem_req fell before imem_ack rose");
    end

  a_addr_stable: assert property (@(posedge clk) disable iff (!rst_n)
    imem_req |=> !imem_req || $stable(imem_addr))
    else begin
      fail_count++;
      $error("imem_addr changed while imem_req was high");
    end

  a_no_early_req: assert property (@(posedge clk) disable iff (!rst_n)
    imem_ack && !imem_req |=> !imem_req)  // Wait for ack to drop first
    else begin
      fail_count++;
      $error("imem_req rose again while imem_ack was still high");
    end

  // Reset values, once the reset has had an edge to act
  a_reset_quiet: assert property (@(posedge clk)
    !rst_n && in_reset_q |-> !imem_req && !trace_val)
    else begin
      fail_count++;
      $error("imem_req or trace_val high during reset");
    end

endmodule

bind blimp_core blimp_core_asserts i_asserts (.*);

// File: test/blimp_core_tb.sv
// Blimp core testbench
// Random ADD/ADDI/MUL program served over the four-phase memory port,
// commit trace checked by the checker, run bounded by a cycle limit
`timescale 1ns/10ps

module blimp_core_tb;
  import blimp_pkg::*;

  localparam int N_INSTR    = 200;
  localparam int MAX_CYCLES = N_INSTR * 40; // Generous per-instruction budget

  logic        clk;
  logic        rst_n;
  logic        imem_req;
  word_t       imem_addr;
  logic        imem_ack;
  word_t       imem_data;
  logic        trace_val;
  word_t       trace_pc;
  reg_idx_t    trace_waddr;
  word_t       trace_wdata;
  logic        trace_wen;
  word_t       prog [N_INSTR];
  int          err_count;
  int          cmt_count;
  int          cycles;
  int          resp_delay;   // Cycles before the next ack
  int          timeouts;
  int          assert_fails;
  reg_idx_t    recent;       // Last destination for reuse as a source

  blimp_core #(.p_seq_num_bits(3), .p_mul_stages(4)) i_dut (.*);

  blimp_core_checker #(.n_instr(N_INSTR)) i_checker (.*);

  initial clk = 1'b0;
  always #10 clk = ~clk; // 20 ns period

  // Sources lean on the previous destination to force stalls
  function automatic reg_idx_t pick_src(reg_idx_t last_rd);
    if ($urandom_range(1, 0) == 1) return last_rd;
    return 5'($urandom_range(7, 0));
  endfunction

  function automatic word_t make_instr(reg_idx_t last_rd);
    int          kind;
    reg_idx_t    rd;
    logic [11:0] imm;
    kind = int'($urandom_range(19, 0));
    rd   = ($urandom_range(7, 0) == 0) ? 5'($urandom_range(31, 0))
                                       : 5'($urandom_range(7, 1));
    imm  = 12'($urandom_range(4095, 0));
    if (kind < 8)                      // ADDI
      return {imm, pick_src(last_rd), 3'b000, rd, OPC_OP_IMM};
    else if (kind < 13)                // ADD
      return {F7_ADD, pick_src(last_rd), pick_src(last_rd), 3'b000, rd, OPC_OP};
    else if (kind < 18)                // MUL
      return {F7_MUL, pick_src(last_rd), pick_src(last_rd), 3'b000, rd, OPC_OP};
    return {imm, pick_src(last_rd), 3'b111, rd, OPC_OP_IMM}; // Unsupported ANDI
  endfunction

  function automatic word_t imem_word(word_t addr);
    int idx;
    idx = int'(addr >> 2);
    if (idx < N_INSTR) return prog[idx];
    return NOP_INSTR;
  endfunction

  //------------------------------------------------------------
  // Instruction memory, four-phase responder
  //------------------------------------------------------------

  always @(posedge clk) begin
    if (!rst_n) begin
      imem_ack   <= 1'b0;
      resp_delay <= 0;
    end else if (imem_ack) begin
      if (!imem_req) imem_ack <= 1'b0; // Close the cycle once req drops
    end else if (imem_req) begin
      if (resp_delay == 0) begin
        imem_data  <= imem_word(imem_addr);
        imem_ack   <= 1'b1;
        resp_delay <= int'($urandom_range(3, 0));
      end else begin
        resp_delay <= resp_delay - 1;
      end
    end
  end

  always @(posedge clk) begin
    if (!rst_n) cycles <= 0;
    else cycles <= cycles + 1;
  end

  //------------------------------------------------------------
  // Main sequence
  //------------------------------------------------------------

  initial begin
    rst_n     = 1'b0;
    imem_ack  = 1'b0;
    imem_data = '0;
    timeouts  = 0;
    void'($urandom(32'h6930_5963));
    recent    = 5'd1;
    for (int i = 0; i < N_INSTR; i++) begin
      prog[i] = make_instr(recent);
      recent  = prog[i][11:7];
    end
    repeat (3) @(posedge clk);
    rst_n <= 1'b1;
    while (cmt_count < N_INSTR && cycles < MAX_CYCLES) @(posedge clk);
    if (cmt_count < N_INSTR) begin
      $display("Timeout after %0d cycles, trace stalled at %0d of %0d commits",
               cycles, cmt_count, N_INSTR);
      timeouts = 1;
    end
    assert_fails = i_dut.i_asserts.fail_count;
    $display("Errors: %0d mismatch, %0d assertion, %0d timeout",
             err_count, assert_fails, timeouts);
    if (err_count == 0 && assert_fails == 0 && timeouts == 0)
      $display("all tests passed");
    else
      $display("tests failed");
    $finish;
  end

endmodule

// File: blimp_core.f
verilog/blimp_pkg.sv
verilog/fetch_unit.sv
verilog/decode_issue_unit.sv
verilog/alu_unit.sv
verilog/mul_unit.sv
verilog/writeback_commit_unit.sv
verilog/blimp_core.sv
test/blimp_core_checker.sv
test/blimp_core_asserts.sv
test/blimp_core_tb.sv

// File: Makefile
# Verilator lint and simulation of the blimp core
TB_TOP = blimp_core_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert --top-module blimp_core -f blimp_core.f

sim:
	verilator --binary --timing --assert -j 0 --top-module $(TB_TOP) -f blimp_core.f
	-./obj_dir/V$(TB_TOP) +verilator+error+limit+1000 > sim.log 2>&1
	@cat sim.log
	@if grep -q "tests failed" sim.log; then exit 1; fi
	@grep -q "all tests passed" sim.log

clean:
	rm -rf obj_dir sim.log
